// ==== Makefile ====
TOP = tb_pdl_unit

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir

// ==== rtl/pdl_pkg.sv ====
// Push-down list package with the stack word, address and command types

package pdl_pkg;

   // ~~~~~~~~~~~~~~~~~~~~
   // Widths
   // ~~~~~~~~~~~~~~~~~~~~

   // Every module's ADDR_W parameter has to match this value
   localparam int PDL_ADDR_W = 10;
   localparam int PDL_WORD_W = 32;

   // ~~~~~~~~~~~~~~~~~~~~
   // Types
   // ~~~~~~~~~~~~~~~~~~~~

   typedef logic [PDL_ADDR_W-1:0] pdl_addr_t;
   typedef logic [PDL_WORD_W-1:0] pdl_word_t;

   // Stack commands from the microcode side
   typedef enum logic [1:0]
   {
      op_push      = 2'd0,
      op_pop       = 2'd1,
      op_read_idx  = 2'd2,
      op_write_idx = 2'd3
   } pdl_op_e;

   // Target of a configuration write
   typedef enum logic
   {
      sel_ptr = 1'b0,
      sel_idx = 1'b1
   } pdl_cfg_sel_e;

endpackage

// ==== rtl/pdl_ram.sv ====
// Dual port synchronous stack RAM with port A write priority and registered reads

`timescale 1ns/1ps

module pdl_ram
#(
   parameter int ADDR_W = 10
)
(
   input  logic    clk_a,
   input  logic    reset,
   pdl_ram_if.ram  port_a,
   pdl_ram_if.ram  port_b
);
   import pdl_pkg::*;

   localparam int DEPTH = 1 << ADDR_W;

   pdl_word_t mem [0:DEPTH-1];

   // ~~~~~~~~~~~~~~~~~~~~
   // Write side
   // ~~~~~~~~~~~~~~~~~~~~

   // Both ports share one write path, and port A wins a collision
   always_ff @(posedge clk_a)
   begin
      if (port_a.wren)
      begin
         mem[port_a.addr] <= port_a.wdata;
      end
      else if (port_b.wren)
      begin
         mem[port_b.addr] <= port_b.wdata;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~
   // Read side
   // ~~~~~~~~~~~~~~~~~~~~

   // Reads see the array before this edge's write, so a mixed port
   // collision returns the old word
   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         port_a.rdata <= '0;
      end
      else if (port_a.rden)
      begin
         port_a.rdata <= mem[port_a.addr];
      end
   end

   // Host side read register holds between reads
   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         port_b.rdata <= '0;
      end
      else if (port_b.rden)
      begin
         port_b.rdata <= mem[port_b.addr];
      end
   end

   // The sequencer issues either a read or a write per access, never both
   a_port_a_single_op: assert property (
      @(posedge clk_a) disable iff (reset)
      !(port_a.wren && port_a.rden)
   ) else $error("pdl_ram: port A read and write in the same cycle");

endmodule

// ==== rtl/pdl_ram_if.sv ====
// One port of the stack RAM, shared by a requester and the memory

`timescale 1ns/1ps

interface pdl_ram_if;
   import pdl_pkg::*;

   pdl_addr_t addr;
   pdl_word_t wdata;
   logic      wren;
   logic      rden;
   // Registered read data, valid the cycle after rden
   pdl_word_t rdata;

   modport requester
   (
      output addr,
      output wdata,
      output wren,
      output rden,
      input  rdata
   );

   modport ram
   (
      input  addr,
      input  wdata,
      input  wren,
      input  rden,
      output rdata
   );

endinterface

// ==== rtl/pdl_regs.sv ====
// Stack pointer and index registers, loaded by configuration and stepped by the sequencer

`timescale 1ns/1ps

module pdl_regs
#(
   parameter int ADDR_W = 10
)
(
   input  logic                   clk_a,
   input  logic                   reset,
   input  logic                   cfg_we,
   input  pdl_pkg::pdl_cfg_sel_e  cfg_sel,
   input  pdl_pkg::pdl_addr_t     cfg_data,
   input  logic                   ptr_inc,
   input  logic                   ptr_dec,
   output pdl_pkg::pdl_addr_t     ptr,
   output pdl_pkg::pdl_addr_t     idx
);
   import pdl_pkg::*;

   logic load_ptr;
   logic load_idx;

   assign load_ptr = cfg_we && (cfg_sel == sel_ptr);
   assign load_idx = cfg_we && (cfg_sel == sel_idx);

   // Configuration loads take priority over the sequencer's steps.
   // Stepping wraps at the top and bottom of the RAM
   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         ptr <= '0;
         idx <= '0;
      end
      else
      begin
         if (load_ptr)
         begin
            ptr <= cfg_data;
         end
         else if (ptr_inc)
         begin
            ptr <= ptr + ADDR_W'(1);
         end
         else if (ptr_dec)
         begin
            ptr <= ptr - ADDR_W'(1);
         end

         if (load_idx)
         begin
            idx <= cfg_data;
         end
      end
   end

   // A push and a pop can't be in their access cycle together
   a_single_step: assert property (
      @(posedge clk_a) disable iff (reset)
      !(ptr_inc && ptr_dec)
   ) else $error("pdl_regs: pointer stepped up and down in one cycle");

endmodule

// ==== rtl/pdl_sequencer.sv ====
// Stack command engine turning each command into one RAM port A access

`timescale 1ns/1ps

module pdl_sequencer
#(
   parameter int ADDR_W = 10
)
(
   input  logic                clk_a,
   input  logic                reset,
   input  logic                cmd_valid,
   output logic                cmd_ready,
   input  pdl_pkg::pdl_op_e    cmd_op,
   input  pdl_pkg::pdl_word_t  cmd_data,
   output logic                rsp_valid,
   input  logic                rsp_ready,
   output pdl_pkg::pdl_word_t  rsp_data,
   input  pdl_pkg::pdl_addr_t  ptr,
   input  pdl_pkg::pdl_addr_t  idx,
   output logic                ptr_inc,
   output logic                ptr_dec,
   pdl_ram_if.requester        ram
);
   import pdl_pkg::*;

   typedef enum logic [1:0] {st_idle, st_access, st_respond} state_e;

   state_e    state;
   pdl_op_e   op_q;
   pdl_word_t data_q;
   logic      is_write;
   logic      in_access;

   assign is_write  = (op_q == op_push) || (op_q == op_write_idx);
   assign in_access = (state == st_access);
   assign cmd_ready = (state == st_idle);

   // ~~~~~~~~~~~~~~~~~~~~
   // Control FSM
   // ~~~~~~~~~~~~~~~~~~~~

   // The respond state spends its first cycle waiting on the RAM read
   // register, then raises rsp_valid and holds until the handshake
   always_ff @(posedge clk_a)
   begin
      if (reset)
      begin
         state     <= st_idle;
         rsp_valid <= 1'b0;
      end
      else
      begin
         case (state)
            st_idle:
               if (cmd_valid)
               begin
                  state <= st_access;
               end
            st_access:
               state <= st_respond;
            st_respond:
               if (!rsp_valid)
               begin
                  rsp_valid <= 1'b1;
               end
               else if (rsp_ready)
               begin
                  rsp_valid <= 1'b0;
                  state     <= st_idle;
               end
            default:
               state <= st_idle;
         endcase
      end
   end

   // Command and response payload
   always_ff @(posedge clk_a)
   begin
      if (cmd_valid && cmd_ready)
      begin
         op_q   <= cmd_op;
         data_q <= cmd_data;
      end
      if ((state == st_respond) && !rsp_valid)
      begin
         rsp_data <= is_write ? data_q : ram.rdata;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~
   // RAM access
   // ~~~~~~~~~~~~~~~~~~~~

   // push writes above the old pointer, pop reads at it
   always_comb
   begin
      case (op_q)
         op_push: ram.addr = ptr + ADDR_W'(1);
         op_pop:  ram.addr = ptr;
         default: ram.addr = idx;
      endcase
   end

   assign ram.wdata = data_q;
   assign ram.wren  = in_access && is_write;
   assign ram.rden  = in_access && !is_write;
   assign ptr_inc   = in_access && (op_q == op_push);
   assign ptr_dec   = in_access && (op_q == op_pop);

   a_rsp_hold: assert property (
      @(posedge clk_a) disable iff (reset)
      rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data)
   ) else $error("pdl_sequencer: response changed while stalled");

endmodule

// ==== rtl/pdl_unit.sv ====
// Push-down list memory unit joining the registers, the sequencer and the stack RAM

`timescale 1ns/1ps

module pdl_unit
#(
   parameter int ADDR_W = 10
)
(
   input  logic                   clk_a,
   input  logic                   reset,
   input  logic                   cmd_valid,
   output logic                   cmd_ready,
   input  pdl_pkg::pdl_op_e       cmd_op,
   input  pdl_pkg::pdl_word_t     cmd_data,
   output logic                   rsp_valid,
   input  logic                   rsp_ready,
   output pdl_pkg::pdl_word_t     rsp_data,
   input  logic                   cfg_we,
   input  pdl_pkg::pdl_cfg_sel_e  cfg_sel,
   input  pdl_pkg::pdl_addr_t     cfg_data,
   input  pdl_pkg::pdl_addr_t     host_addr,
   input  pdl_pkg::pdl_word_t     host_wdata,
   input  logic                   host_we,
   input  logic                   host_re,
   output pdl_pkg::pdl_word_t     host_rdata,
   output pdl_pkg::pdl_addr_t     ptr,
   output pdl_pkg::pdl_addr_t     idx
);
   import pdl_pkg::*;

   logic ptr_inc;
   logic ptr_dec;

   pdl_ram_if port_a_if ();
   pdl_ram_if port_b_if ();

   // Host side goes straight onto RAM port B
   assign port_b_if.addr  = host_addr;
   assign port_b_if.wdata = host_wdata;
   assign port_b_if.wren  = host_we;
   assign port_b_if.rden  = host_re;
   assign host_rdata      = port_b_if.rdata;

   pdl_regs #(.ADDR_W(ADDR_W)) u_regs
   (
      .clk_a    (clk_a),
      .reset    (reset),
      .cfg_we   (cfg_we),
      .cfg_sel  (cfg_sel),
      .cfg_data (cfg_data),
      .ptr_inc  (ptr_inc),
      .ptr_dec  (ptr_dec),
      .ptr      (ptr),
      .idx      (idx)
   );

   pdl_sequencer #(.ADDR_W(ADDR_W)) u_sequencer
   (
      .clk_a     (clk_a),
      .reset     (reset),
      .cmd_valid (cmd_valid),
      .cmd_ready (cmd_ready),
      .cmd_op    (cmd_op),
      .cmd_data  (cmd_data),
      .rsp_valid (rsp_valid),
      .rsp_ready (rsp_ready),
      .rsp_data  (rsp_data),
      .ptr       (ptr),
      .idx       (idx),
      .ptr_inc   (ptr_inc),
      .ptr_dec   (ptr_dec),
      .ram       (port_a_if.requester)
   );

   pdl_ram #(.ADDR_W(ADDR_W)) u_ram
   (
      .clk_a  (clk_a),
      .reset  (reset),
      .port_a (port_a_if.ram),
      .port_b (port_b_if.ram)
   );

   // Address types come from the package, so the depth must agree with it
   a_addr_w_match: assert property (
      @(posedge clk_a) ADDR_W == PDL_ADDR_W
   ) else $error("pdl_unit: ADDR_W differs from the package address width");

endmodule

// ==== verif/pdl_ref_model.svh ====
// Reference model of the stack memory, pointer and index, with a value compare task
`ifndef PDL_REF_MODEL_SVH
`define PDL_REF_MODEL_SVH

pdl_word_t model_mem [0:1023];
pdl_addr_t model_ptr;
pdl_addr_t model_idx;

// Applies one stack command to the model and returns the expected response word
function automatic pdl_word_t model_apply(input pdl_op_e op, input pdl_word_t data);
   pdl_word_t result;
   result = data;
   case (op)
      op_push:
      begin
         model_ptr = model_ptr + 10'd1;
         model_mem[model_ptr] = data;
      end
      op_pop:
      begin
         result = model_mem[model_ptr];
         model_ptr = model_ptr - 10'd1;
      end
      op_read_idx:
         result = model_mem[model_idx];
      default:
         model_mem[model_idx] = data;
   endcase
   return result;
endfunction

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
   if (got !== exp)
   begin
      $display("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "Mismatch on %s", name);
   end
endtask

`endif

// ==== verif/tb_pdl_unit.sv ====
// Testbench for the push-down list unit with a seeded random model comparison

`timescale 1ns/1ps

module tb_pdl_unit;
   import pdl_pkg::*;

   localparam int N_PUSH_POP  = 400;
   localparam int N_IDX       = 150;
   localparam int N_LOADED    = 8;
   localparam int N_STALL     = 100;
   localparam int N_COLLIDE   = 16;
   localparam int TOTAL_CMDS  = N_PUSH_POP + N_IDX + N_LOADED + N_STALL + N_COLLIDE;
   localparam int CYCLE_LIMIT = 4 * TOTAL_CMDS + 2000;

   logic         clk_a;
   logic         reset;
   logic         cmd_valid;
   logic         cmd_ready;
   pdl_op_e      cmd_op;
   pdl_word_t    cmd_data;
   logic         rsp_valid;
   logic         rsp_ready;
   pdl_word_t    rsp_data;
   logic         cfg_we;
   pdl_cfg_sel_e cfg_sel;
   pdl_addr_t    cfg_data;
   pdl_addr_t    host_addr;
   pdl_word_t    host_wdata;
   logic         host_we;
   logic         host_re;
   pdl_word_t    host_rdata;
   pdl_addr_t    ptr;
   pdl_addr_t    idx;
   integer       seed;
   integer       cycle_count;

   `include "pdl_ref_model.svh"

   pdl_unit #(.ADDR_W(PDL_ADDR_W)) UUT
   (
      .clk_a      (clk_a),
      .reset      (reset),
      .cmd_valid  (cmd_valid),
      .cmd_ready  (cmd_ready),
      .cmd_op     (cmd_op),
      .cmd_data   (cmd_data),
      .rsp_valid  (rsp_valid),
      .rsp_ready  (rsp_ready),
      .rsp_data   (rsp_data),
      .cfg_we     (cfg_we),
      .cfg_sel    (cfg_sel),
      .cfg_data   (cfg_data),
      .host_addr  (host_addr),
      .host_wdata (host_wdata),
      .host_we    (host_we),
      .host_re    (host_re),
      .host_rdata (host_rdata),
      .ptr        (ptr),
      .idx        (idx)
   );

   initial
   begin
      clk_a = 1'b0;
      forever #10 clk_a = ~clk_a;
   end

   initial
   begin
      cycle_count = 0;
      while (cycle_count < CYCLE_LIMIT)
      begin
         @(posedge clk_a);
         cycle_count++;
      end
      $display("Timeout: the run went past %0d cycles without finishing", CYCLE_LIMIT);
      $display("RESULT: FAIL");
      $fatal(1, "Timeout");
   end

   // ~~~~~~~~~~~~~~~~~~~~
   // Bus tasks
   // ~~~~~~~~~~~~~~~~~~~~

   task automatic write_cfg(input pdl_cfg_sel_e sel, input pdl_addr_t value);
      cfg_we   = 1'b1;
      cfg_sel  = sel;
      cfg_data = value;
      @(posedge clk_a);
      #2;
      cfg_we = 1'b0;
      if (sel == sel_ptr)
         model_ptr = value;
      else
         model_idx = value;
      check_value("ptr", 32'(ptr), 32'(model_ptr));
      check_value("idx", 32'(idx), 32'(model_idx));
   endtask

   task automatic write_host(input pdl_addr_t addr, input pdl_word_t data);
      host_addr  = addr;
      host_wdata = data;
      host_we    = 1'b1;
      @(posedge clk_a);
      #2;
      host_we = 1'b0;
      model_mem[addr] = data;
   endtask

   task automatic read_host(input pdl_addr_t addr);
      host_addr = addr;
      host_re   = 1'b1;
      @(posedge clk_a);
      #2;
      host_re = 1'b0;
      check_value("host_rdata", host_rdata, model_mem[addr]);
   endtask

   // One command through to its response, with optional stall and a host
   // write placed in the port A access cycle
   task automatic run_cmd(input pdl_op_e op, input pdl_word_t data, input bit stall,
                          input bit collide, input pdl_addr_t h_addr, input pdl_word_t h_data);
      pdl_word_t expected;
      int        latency;
      int        hold;
      expected  = model_apply(op, data);
      cmd_valid = 1'b1;
      cmd_op    = op;
      cmd_data  = data;
      while (!cmd_ready)
      begin
         @(posedge clk_a);
         #2;
      end
      @(posedge clk_a);
      #2;
      // A pop left on the bus during a stall would move ptr if it got in
      cmd_valid = stall;
      cmd_op    = op_pop;
      if (collide)
      begin
         host_addr  = h_addr;
         host_wdata = h_data;
         host_we    = 1'b1;
      end
      hold      = stall ? 1 + ($random(seed) & 3) : 0;
      rsp_ready = !stall;
      latency   = 0;
      while (!rsp_valid)
      begin
         check_value("cmd_ready", 32'(cmd_ready), 32'd0);
         @(posedge clk_a);
         #2;
         host_we = 1'b0;
         latency++;
      end
      check_value("rsp latency", 32'(latency), 32'd2);
      while (hold > 0)
      begin
         check_value("rsp_data", rsp_data, expected);
         check_value("cmd_ready", 32'(cmd_ready), 32'd0);
         @(posedge clk_a);
         #2;
         check_value("rsp_valid", 32'(rsp_valid), 32'd1);
         hold--;
      end
      rsp_ready = 1'b1;
      check_value("rsp_data", rsp_data, expected);
      @(posedge clk_a);
      #2;
      cmd_valid = 1'b0;
      check_value("rsp_valid", 32'(rsp_valid), 32'd0);
      check_value("cmd_ready", 32'(cmd_ready), 32'd1);
      check_value("ptr", 32'(ptr), 32'(model_ptr));
   endtask

   // ~~~~~~~~~~~~~~~~~~~~
   // Test sequence
   // ~~~~~~~~~~~~~~~~~~~~

   initial
   begin
      integer    r;
      pdl_op_e   op;
      pdl_addr_t ha;
      seed       = 32'hd323;
      reset      = 1'b1;
      cmd_valid  = 1'b0;
      cmd_op     = op_push;
      cmd_data   = '0;
      rsp_ready  = 1'b1;
      cfg_we     = 1'b0;
      cfg_sel    = sel_ptr;
      cfg_data   = '0;
      host_addr  = '0;
      host_wdata = '0;
      host_we    = 1'b0;
      host_re    = 1'b0;
      model_ptr  = '0;
      model_idx  = '0;
      repeat (8) @(posedge clk_a);
      #2;
      reset = 1'b0;

      check_value("ptr", 32'(ptr), 32'd0);
      check_value("idx", 32'(idx), 32'd0);
      check_value("rsp_valid", 32'(rsp_valid), 32'd0);
      check_value("cmd_ready", 32'(cmd_ready), 32'd1);
      check_value("host_rdata", host_rdata, 32'd0);

      // RAM contents start unknown, so fill every word through the host port
      for (int i = 0; i < 1024; i++)
         write_host(pdl_addr_t'(i), pdl_word_t'((32'(i) * 32'h9e3779b1) ^ 32'hc3a50000));

      // Opening with a pop wraps the empty stack to the top of the RAM
      for (int i = 0; i < N_PUSH_POP; i++)
      begin
         r  = $random(seed);
         op = (i == 0 || r[0]) ? op_pop : op_push;
         run_cmd(op, $random(seed), 1'b0, 1'b0, '0, '0);
      end

      write_cfg(sel_idx, pdl_addr_t'($random(seed)));
      for (int i = 0; i < N_IDX; i++)
      begin
         if (i % 10 == 9)
            write_cfg(sel_idx, pdl_addr_t'($random(seed)));
         r  = $random(seed);
         op = r[1] ? op_write_idx : op_read_idx;
         run_cmd(op, $random(seed), 1'b0, 1'b0, '0, '0);
      end
      write_cfg(sel_ptr, pdl_addr_t'($random(seed)));
      for (int i = 0; i < N_LOADED; i++)
         run_cmd((i < N_LOADED / 2) ? op_push : op_pop, $random(seed), 1'b0, 1'b0, '0, '0);

      for (int i = 0; i < N_STALL; i++)
      begin
         r  = $random(seed);
         op = pdl_op_e'(r[1:0]);
         run_cmd(op, $random(seed), 1'b1, 1'b0, '0, '0);
      end

      // Host port with the command side idle
      for (int i = 0; i < 32; i++)
      begin
         ha = pdl_addr_t'($random(seed));
         write_host(ha, $random(seed));
         read_host(ha);
      end
      host_addr = ha + 10'd1;
      @(posedge clk_a);
      #2;
      check_value("host_rdata hold", host_rdata, model_mem[ha]);
      for (int k = 0; k < 16; k++)
         read_host(model_ptr - pdl_addr_t'(k));

      // Host writes that land in a write_idx access cycle are lost
      for (int i = 0; i < N_COLLIDE; i++)
      begin
         write_cfg(sel_idx, pdl_addr_t'($random(seed)));
         ha = pdl_addr_t'($random(seed));
         if (ha == model_idx)
            ha = ha + 10'd1;
         run_cmd(op_write_idx, $random(seed), 1'b0, 1'b1, ha, $random(seed));
         read_host(ha);
      end

      $display("RESULT: PASS");
      $finish;
   end

endmodule

// ==== verilog.f ====
+incdir+verif
rtl/pdl_pkg.sv
rtl/pdl_ram_if.sv
rtl/pdl_ram.sv
rtl/pdl_regs.sv
rtl/pdl_sequencer.sv
rtl/pdl_unit.sv
verif/tb_pdl_unit.sv
